// ==== common/timer_cfg_pkg.sv ====
package timer_cfg_pkg;

    // 32-bit register word, also used for prescale, reload and counts
    typedef logic [31:0] word_t;

    // word address on the register bus
    typedef logic [4:0] addr_t;

    // one enable per byte lane
    typedef logic [3:0] be_t;

    localparam int unsigned NUM_CHANNELS = 2;

    // prescale value that selects the default divide
    localparam word_t PRESCALE_ALL_ONES = '1;

    // default divide when the top level does not override it
    localparam word_t DIVIDE_DEFAULT = 32'd999;

endpackage

// ==== common/timer_ctrl_if.sv ====
`timescale 1ns/1ps

interface timer_ctrl_if;

    // register side settings
    timer_cfg_pkg::word_t pre;
    timer_cfg_pkg::word_t are;
    logic                 ena;
    logic                 mod;
    logic                 clr_pulse;
    logic                 evc_pulse;
    logic                 cnt_wr;
    timer_cfg_pkg::word_t cnt_wdata;

    // channel side status
    timer_cfg_pkg::word_t cnt;
    timer_cfg_pkg::word_t evn;
    logic                 event_pulse;

    modport regs (
        output pre, are, ena, mod,
        output clr_pulse, evc_pulse,
        output cnt_wr, cnt_wdata,
        input  cnt, evn, event_pulse
    );

    modport chan (
        input  pre, are, ena, mod,
        input  clr_pulse, evc_pulse,
        input  cnt_wr, cnt_wdata,
        output cnt, evn, event_pulse
    );

endinterface

// ==== common/timer_map_pkg.sv ====
package timer_map_pkg;

    // word offsets inside one channel window
    localparam timer_cfg_pkg::addr_t REG_PRE  = 5'd0;
    localparam timer_cfg_pkg::addr_t REG_ARE  = 5'd1;
    localparam timer_cfg_pkg::addr_t REG_CTRL = 5'd2;
    localparam timer_cfg_pkg::addr_t REG_CNT  = 5'd3;
    localparam timer_cfg_pkg::addr_t REG_EVN  = 5'd4;

    // distance between channel windows, a power of two
    localparam int unsigned CH_STRIDE = 8;

    // interrupt registers above the channel windows
    localparam timer_cfg_pkg::addr_t REG_IRQ_PEND = 5'd16;
    localparam timer_cfg_pkg::addr_t REG_IRQ_MASK = 5'd17;

    // stored control bits
    localparam int unsigned CTRL_ENA = 0;
    localparam int unsigned CTRL_MOD = 1;

    // write-one actions, read back as zero
    localparam int unsigned CTRL_CLR = 2;
    localparam int unsigned CTRL_EVC = 3;

endpackage

// ==== project.f ====
common/timer_cfg_pkg.sv
common/timer_map_pkg.sv
common/timer_ctrl_if.sv
timer/timer_channel.sv
timer/timer_regs.sv
source/irq_merge.sv
source/timer_top.sv
verification/timer_assertions.sv
verification/timer_tb.sv

// ==== source/irq_merge.sv ====
`timescale 1ns/1ps

module irq_merge (
    input  logic                                   clk_i,
    input  logic                                   rst_i,
    input  logic [timer_cfg_pkg::NUM_CHANNELS-1:0] event_i,
    input  logic [timer_cfg_pkg::NUM_CHANNELS-1:0] mask_i,
    input  logic                                   irq_ack_i,
    output logic [timer_cfg_pkg::NUM_CHANNELS-1:0] pend_o,
    output logic                                   irq_o
);

    localparam int unsigned NCH = timer_cfg_pkg::NUM_CHANNELS;

    logic [NCH-1:0] pend_q;
    logic [NCH-1:0] pend_next;
    logic           irq_q;

    // ack clears everything, a new event in the same cycle survives
    assign pend_next = (pend_q & ~{NCH{irq_ack_i}}) | event_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pend_q <= '0;
            irq_q  <= 1'b0;
        end else begin
            pend_q <= pend_next;
            // built from next pending state so irq_o lines up with pend_o
            irq_q  <= |(pend_next & mask_i);
        end
    end

    assign pend_o = pend_q;
    assign irq_o  = irq_q;

endmodule

// ==== source/timer_top.sv ====
`timescale 1ns/1ps

module timer_top #(
    parameter timer_cfg_pkg::word_t DEFAULT_DIVIDE = timer_cfg_pkg::DIVIDE_DEFAULT
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 req_i,
    input  logic                 write_i,
    input  timer_cfg_pkg::addr_t addr_i,
    input  timer_cfg_pkg::be_t   be_i,
    input  timer_cfg_pkg::word_t wdata_i,
    input  logic                 irq_ack_i,
    output logic                 ack_o,
    output timer_cfg_pkg::word_t rdata_o,
    output logic                 irq_o
);

    logic [timer_cfg_pkg::NUM_CHANNELS-1:0] chan_event;
    logic [timer_cfg_pkg::NUM_CHANNELS-1:0] irq_pend;
    logic [timer_cfg_pkg::NUM_CHANNELS-1:0] irq_mask;

    timer_ctrl_if u_ctrl0 ();
    timer_ctrl_if u_ctrl1 ();

    timer_regs u_regs (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .req_i      (req_i),
        .write_i    (write_i),
        .addr_i     (addr_i),
        .be_i       (be_i),
        .wdata_i    (wdata_i),
        .irq_pend_i (irq_pend),
        .ack_o      (ack_o),
        .rdata_o    (rdata_o),
        .irq_mask_o (irq_mask),
        .ctrl0      (u_ctrl0.regs),
        .ctrl1      (u_ctrl1.regs)
    );

    timer_channel #(
        .DEFAULT_DIVIDE (DEFAULT_DIVIDE)
    ) u_chan0 (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .ctrl  (u_ctrl0.chan)
    );

    timer_channel #(
        .DEFAULT_DIVIDE (DEFAULT_DIVIDE)
    ) u_chan1 (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .ctrl  (u_ctrl1.chan)
    );

    // channel events in channel order
    assign chan_event = {u_ctrl1.event_pulse, u_ctrl0.event_pulse};

    irq_merge u_irq (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .event_i   (chan_event),
        .mask_i    (irq_mask),
        .irq_ack_i (irq_ack_i),
        .pend_o    (irq_pend),
        .irq_o     (irq_o)
    );

endmodule

// ==== timer/timer_channel.sv ====
`timescale 1ns/1ps

module timer_channel #(
    parameter timer_cfg_pkg::word_t DEFAULT_DIVIDE = timer_cfg_pkg::DIVIDE_DEFAULT
) (
    input  logic         clk_i,
    input  logic         rst_i,
    timer_ctrl_if.chan   ctrl
);

    timer_cfg_pkg::word_t divide;
    timer_cfg_pkg::word_t psc_q;
    timer_cfg_pkg::word_t cnt_q;
    timer_cfg_pkg::word_t evn_q;
    logic                 event_q;
    logic                 tick;
    logic                 reload_hit;

    // all ones in pre falls back to the default divide
    assign divide = (ctrl.pre == timer_cfg_pkg::PRESCALE_ALL_ONES) ? DEFAULT_DIVIDE
                                                                  : ctrl.pre;

    // >= so a smaller divide written on the fly does not stall the prescaler
    assign tick       = ctrl.ena && (psc_q >= divide);
    assign reload_hit = tick && (cnt_q == ctrl.are);

    // prescaler, held at zero while disabled
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            psc_q <= '0;
        end else if (!ctrl.ena || tick) begin
            psc_q <= '0;
        end else begin
            psc_q <= psc_q + 1'b1;
        end
    end

    // main count and event count
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q   <= '0;
            evn_q   <= '0;
            event_q <= 1'b0;
        end else begin
            event_q <= reload_hit;

            if (reload_hit) begin
                cnt_q <= '0;
                evn_q <= evn_q + 1'b1;
            end else if (tick) begin
                if (ctrl.mod) begin
                    cnt_q <= cnt_q + 1'b1;
                end else begin
                    cnt_q <= cnt_q - 1'b1;
                end
            end

            // software load, then clears override everything
            if (ctrl.cnt_wr) begin
                cnt_q <= ctrl.cnt_wdata;
            end
            if (ctrl.clr_pulse) begin
                cnt_q <= '0;
            end
            if (ctrl.evc_pulse) begin
                evn_q <= '0;
            end
        end
    end

    assign ctrl.cnt         = cnt_q;
    assign ctrl.evn         = evn_q;
    assign ctrl.event_pulse = event_q;

endmodule

// ==== timer/timer_regs.sv ====
`timescale 1ns/1ps

module timer_regs (
    input  logic                                         clk_i,
    input  logic                                         rst_i,
    input  logic                                         req_i,
    input  logic                                         write_i,
    input  timer_cfg_pkg::addr_t                         addr_i,
    input  timer_cfg_pkg::be_t                           be_i,
    input  timer_cfg_pkg::word_t                         wdata_i,
    input  logic [timer_cfg_pkg::NUM_CHANNELS-1:0]       irq_pend_i,
    output logic                                         ack_o,
    output timer_cfg_pkg::word_t                         rdata_o,
    output logic [timer_cfg_pkg::NUM_CHANNELS-1:0]       irq_mask_o,
    timer_ctrl_if.regs                                   ctrl0,
    timer_ctrl_if.regs                                   ctrl1
);

    localparam int unsigned NCH        = timer_cfg_pkg::NUM_CHANNELS;
    localparam int unsigned STRIDE_BIT = $clog2(timer_map_pkg::CH_STRIDE);
    localparam int unsigned CH_BITS    = (NCH > 1) ? $clog2(NCH) : 1;

    typedef enum logic [1:0] {
        IDLE,
        ACK,
        WAIT_DROP
    } chan_state_e;

    chan_state_e          state_q;
    timer_cfg_pkg::word_t pre_q       [NCH];
    timer_cfg_pkg::word_t are_q       [NCH];
    logic                 ena_q       [NCH];
    logic                 mod_q       [NCH];
    logic                 clr_q       [NCH];
    logic                 evc_q       [NCH];
    logic                 cnt_wr_q    [NCH];
    timer_cfg_pkg::word_t cnt_wdata_q [NCH];
    timer_cfg_pkg::word_t cnt_live    [NCH];
    timer_cfg_pkg::word_t evn_live    [NCH];
    timer_cfg_pkg::word_t ctrl_rd     [NCH];
    logic [NCH-1:0]       mask_q;
    timer_cfg_pkg::word_t rdata_q;
    timer_cfg_pkg::word_t rd_mux;
    timer_cfg_pkg::word_t mask_merged;
    timer_cfg_pkg::word_t ctrl_merged;
    timer_cfg_pkg::addr_t chan_off;
    logic [CH_BITS-1:0]   ch_sel;
    logic                 in_window;
    logic                 accept;
    logic                 wr_en;

    // byte lane merge of a write into the current value
    function automatic timer_cfg_pkg::word_t merge_be(timer_cfg_pkg::word_t old_val,
                                                      timer_cfg_pkg::word_t new_val,
                                                      timer_cfg_pkg::be_t be);
        timer_cfg_pkg::word_t res;
        res = old_val;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_val[8*b +: 8];
            end
        end
        return res;
    endfunction

    // address decode
    assign in_window = addr_i < timer_cfg_pkg::addr_t'(NCH * timer_map_pkg::CH_STRIDE);
    assign chan_off  = addr_i & timer_cfg_pkg::addr_t'(timer_map_pkg::CH_STRIDE - 1);
    assign ch_sel    = addr_i[STRIDE_BIT +: CH_BITS];
    assign accept    = (state_q == IDLE) && req_i;
    assign wr_en     = accept && write_i;

    assign cnt_live[0] = ctrl0.cnt;
    assign cnt_live[1] = ctrl1.cnt;
    assign evn_live[0] = ctrl0.evn;
    assign evn_live[1] = ctrl1.evn;

    always_comb begin
        for (int i = 0; i < NCH; i++) begin
            ctrl_rd[i] = '0;
            ctrl_rd[i][timer_map_pkg::CTRL_ENA] = ena_q[i];
            ctrl_rd[i][timer_map_pkg::CTRL_MOD] = mod_q[i];
        end
    end

    assign mask_merged = merge_be(timer_cfg_pkg::word_t'(mask_q), wdata_i, be_i);
    assign ctrl_merged = merge_be(ctrl_rd[ch_sel], wdata_i, be_i);

    // read mux with zero for unmapped reads
    always_comb begin
        rd_mux = '0;
        if (in_window) begin
            case (chan_off)
                timer_map_pkg::REG_PRE:  rd_mux = pre_q[ch_sel];
                timer_map_pkg::REG_ARE:  rd_mux = are_q[ch_sel];
                timer_map_pkg::REG_CTRL: rd_mux = ctrl_rd[ch_sel];
                timer_map_pkg::REG_CNT:  rd_mux = cnt_live[ch_sel];
                timer_map_pkg::REG_EVN:  rd_mux = evn_live[ch_sel];
                default:                 rd_mux = '0;
            endcase
        end else if (addr_i == timer_map_pkg::REG_IRQ_PEND) begin
            rd_mux = timer_cfg_pkg::word_t'(irq_pend_i);
        end else if (addr_i == timer_map_pkg::REG_IRQ_MASK) begin
            rd_mux = timer_cfg_pkg::word_t'(mask_q);
        end
    end

    // four-phase handshake and register writes
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
            mask_q  <= '0;
            for (int i = 0; i < NCH; i++) begin
                pre_q[i]    <= '0;
                are_q[i]    <= '0;
                ena_q[i]    <= 1'b0;
                mod_q[i]    <= 1'b0;
                clr_q[i]    <= 1'b0;
                evc_q[i]    <= 1'b0;
                cnt_wr_q[i] <= 1'b0;
            end
        end else begin
            case (state_q)
                IDLE:      state_q <= req_i ? ACK : IDLE;
                ACK:       state_q <= req_i ? WAIT_DROP : IDLE;
                WAIT_DROP: state_q <= req_i ? WAIT_DROP : IDLE;
                default:   state_q <= IDLE;
            endcase

            for (int i = 0; i < NCH; i++) begin
                clr_q[i]    <= 1'b0;
                evc_q[i]    <= 1'b0;
                cnt_wr_q[i] <= 1'b0;
                if (wr_en && in_window && (ch_sel == CH_BITS'(i))) begin
                    case (chan_off)
                        timer_map_pkg::REG_PRE: pre_q[i] <= merge_be(pre_q[i], wdata_i, be_i);
                        timer_map_pkg::REG_ARE: are_q[i] <= merge_be(are_q[i], wdata_i, be_i);
                        timer_map_pkg::REG_CTRL: begin
                            ena_q[i] <= ctrl_merged[timer_map_pkg::CTRL_ENA];
                            mod_q[i] <= ctrl_merged[timer_map_pkg::CTRL_MOD];
                            clr_q[i] <= ctrl_merged[timer_map_pkg::CTRL_CLR];
                            evc_q[i] <= ctrl_merged[timer_map_pkg::CTRL_EVC];
                        end
                        timer_map_pkg::REG_CNT: cnt_wr_q[i] <= 1'b1;
                        default: ;
                    endcase
                end
            end

            if (wr_en && (addr_i == timer_map_pkg::REG_IRQ_MASK)) begin
                mask_q <= mask_merged[NCH-1:0];
            end
        end
    end

    // read data and count load value
    always_ff @(posedge clk_i) begin
        if (accept) begin
            rdata_q <= rd_mux;
        end
        for (int i = 0; i < NCH; i++) begin
            if (wr_en && in_window && (ch_sel == CH_BITS'(i))) begin
                cnt_wdata_q[i] <= merge_be(cnt_live[i], wdata_i, be_i);
            end
        end
    end

    assign ack_o      = (state_q != IDLE);
    assign rdata_o    = rdata_q;
    assign irq_mask_o = mask_q;

    assign ctrl0.pre       = pre_q[0];
    assign ctrl0.are       = are_q[0];
    assign ctrl0.ena       = ena_q[0];
    assign ctrl0.mod       = mod_q[0];
    assign ctrl0.clr_pulse = clr_q[0];
    assign ctrl0.evc_pulse = evc_q[0];
    assign ctrl0.cnt_wr    = cnt_wr_q[0];
    assign ctrl0.cnt_wdata = cnt_wdata_q[0];

    assign ctrl1.pre       = pre_q[1];
    assign ctrl1.are       = are_q[1];
    assign ctrl1.ena       = ena_q[1];
    assign ctrl1.mod       = mod_q[1];
    assign ctrl1.clr_pulse = clr_q[1];
    assign ctrl1.evc_pulse = evc_q[1];
    assign ctrl1.cnt_wr    = cnt_wr_q[1];
    assign ctrl1.cnt_wdata = cnt_wdata_q[1];

endmodule

// ==== verification/timer_assertions.sv ====
`timescale 1ns/1ps

module timer_assertions (
    input logic                                   clk_i,
    input logic                                   rst_i,
    input logic                                   req_i,
    input logic                                   ack_o,
    input logic                                   irq_o,
    input logic                                   irq_ack_i,
    input logic [timer_cfg_pkg::NUM_CHANNELS-1:0] event_i,
    input logic [timer_cfg_pkg::NUM_CHANNELS-1:0] pend_i
);

    // read by the testbench
    int fail_count = 0;

    // ack may only answer a request that was seen high
    ack_rise_on_req: assert property (
        @(posedge clk_i) disable iff (rst_i) $rose(ack_o) |-> $past(req_i)
    ) else begin
        fail_count++;
        $error("ack_o rose without a request");
    end

    // ack is released only once the master let go of req
    ack_fall_after_drop: assert property (
        @(posedge clk_i) disable iff (rst_i) $fell(ack_o) |-> !$past(req_i)
    ) else begin
        fail_count++;
        $error("ack_o fell while req_i was still high");
    end

    // an acknowledge without a new event leaves no pending bit and no interrupt
    ack_clears_irq: assert property (
        @(posedge clk_i) disable iff (rst_i)
            irq_ack_i && (event_i == '0) |=> (pend_i == '0) && !irq_o
    ) else begin
        fail_count++;
        $error("pending bit or irq_o still set after an acknowledge");
    end

endmodule

bind timer_top timer_assertions u_assertions (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .req_i     (req_i),
    .ack_o     (ack_o),
    .irq_o     (irq_o),
    .irq_ack_i (irq_ack_i),
    .event_i   (chan_event),
    .pend_i    (irq_pend)
);

// ==== verification/timer_tb.sv ====
`timescale 1ns/1ps

module timer_tb;

    localparam int CLK_PERIOD = 100;
    localparam timer_cfg_pkg::word_t DIVIDE = 32'd5;
    // cycle budget of each test plus the reset
    localparam int TEST_CYCLES = 16 + 1100 + 600 + 400 + 250 + 400 + 150;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES * 12 / 10;

    logic                 clk_i;
    logic                 rst_i;
    logic                 req_i;
    logic                 write_i;
    timer_cfg_pkg::addr_t addr_i;
    timer_cfg_pkg::be_t   be_i;
    timer_cfg_pkg::word_t wdata_i;
    logic                 irq_ack_i;
    logic                 ack_o;
    timer_cfg_pkg::word_t rdata_o;
    logic                 irq_o;

    logic [31:0]          lfsr_state = 32'h2e6f_7d7e;
    int                   hold_extra = 0;
    timer_cfg_pkg::addr_t unmapped [9] = '{5, 6, 7, 13, 14, 15, 18, 25, 31};

    // reference model state
    timer_cfg_pkg::word_t m_pre [2];
    timer_cfg_pkg::word_t m_are [2];
    timer_cfg_pkg::word_t m_cnt [2];
    timer_cfg_pkg::word_t m_evn [2];
    timer_cfg_pkg::word_t m_psc [2];
    timer_cfg_pkg::word_t m_cntwd [2];
    logic                 m_ena [2];
    logic                 m_mod [2];
    logic                 m_clr [2];
    logic                 m_evc [2];
    logic                 m_cntwr [2];
    logic                 m_evp [2];
    logic [1:0]           m_pend;
    logic [1:0]           m_mask;
    logic                 m_irq;
    logic                 m_busy;
    timer_cfg_pkg::word_t m_rdata;

    timer_top #(
        .DEFAULT_DIVIDE (DIVIDE)
    ) u_dut (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .req_i     (req_i),
        .write_i   (write_i),
        .addr_i    (addr_i),
        .be_i      (be_i),
        .wdata_i   (wdata_i),
        .irq_ack_i (irq_ack_i),
        .ack_o     (ack_o),
        .rdata_o   (rdata_o),
        .irq_o     (irq_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // galois LFSR stepping once per bit taken
    function automatic logic [31:0] random_bits(int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    function automatic timer_cfg_pkg::word_t merge_bytes(timer_cfg_pkg::word_t old_v,
                                                         timer_cfg_pkg::word_t new_v,
                                                         timer_cfg_pkg::be_t be);
        timer_cfg_pkg::word_t res;
        res = old_v;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_v[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic timer_cfg_pkg::addr_t chan_addr(int ch, timer_cfg_pkg::addr_t off);
        return timer_cfg_pkg::addr_t'(ch * timer_map_pkg::CH_STRIDE) + off;
    endfunction

    // register contents as the model sees them
    function automatic timer_cfg_pkg::word_t model_read(timer_cfg_pkg::addr_t a);
        int ch;
        int off;
        ch  = int'(a) / timer_map_pkg::CH_STRIDE;
        off = int'(a) % timer_map_pkg::CH_STRIDE;
        if (ch < timer_cfg_pkg::NUM_CHANNELS) begin
            case (off)
                timer_map_pkg::REG_PRE:  return m_pre[ch];
                timer_map_pkg::REG_ARE:  return m_are[ch];
                timer_map_pkg::REG_CTRL: return {30'b0, m_mod[ch], m_ena[ch]};
                timer_map_pkg::REG_CNT:  return m_cnt[ch];
                timer_map_pkg::REG_EVN:  return m_evn[ch];
                default:                 return '0;
            endcase
        end
        if (a == timer_map_pkg::REG_IRQ_PEND) begin
            return {30'b0, m_pend};
        end
        if (a == timer_map_pkg::REG_IRQ_MASK) begin
            return {30'b0, m_mask};
        end
        return '0;
    endfunction

    task automatic report_fail(string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_value(string name, timer_cfg_pkg::word_t got,
                               timer_cfg_pkg::word_t exp);
        assert (got === exp) else begin
            report_fail($sformatf("Mismatch at %0t: %s got %h expected %h",
                                  $time, name, got, exp));
        end
    endtask

    // cycle model of both channels, the merger and the bus
    always @(posedge clk_i) begin : model
        timer_cfg_pkg::word_t cnt_old [2];
        timer_cfg_pkg::word_t div;
        timer_cfg_pkg::word_t merged;
        logic [1:0]           pend_new;
        logic                 tick;
        logic                 accept;
        int                   ch;
        int                   off;
        if (rst_i) begin
            for (int c = 0; c < 2; c++) begin
                m_pre[c]   = '0;
                m_are[c]   = '0;
                m_cnt[c]   = '0;
                m_evn[c]   = '0;
                m_psc[c]   = '0;
                m_cntwd[c] = '0;
                m_ena[c]   = 1'b0;
                m_mod[c]   = 1'b0;
                m_clr[c]   = 1'b0;
                m_evc[c]   = 1'b0;
                m_cntwr[c] = 1'b0;
                m_evp[c]   = 1'b0;
            end
            m_pend  = '0;
            m_mask  = '0;
            m_irq   = 1'b0;
            m_busy  = 1'b0;
            m_rdata = '0;
        end else begin
            accept  = req_i && !m_busy;
            cnt_old = m_cnt;
            if (accept) begin
                m_rdata = model_read(addr_i);
            end

            // an event in the acknowledge cycle stays pending
            pend_new = (m_pend & ~{2{irq_ack_i}}) | {m_evp[1], m_evp[0]};
            m_irq    = |(pend_new & m_mask);
            m_pend   = pend_new;

            for (int c = 0; c < 2; c++) begin
                div      = (m_pre[c] == '1) ? DIVIDE : m_pre[c];
                tick     = m_ena[c] && (m_psc[c] == div);
                m_evp[c] = tick && (m_cnt[c] == m_are[c]);
                m_psc[c] = (!m_ena[c] || tick) ? '0 : m_psc[c] + 1;
                if (m_evp[c]) begin
                    m_cnt[c] = '0;
                    m_evn[c] = m_evn[c] + 1;
                end else if (tick) begin
                    m_cnt[c] = m_mod[c] ? m_cnt[c] + 1 : m_cnt[c] - 1;
                end
                if (m_cntwr[c]) begin
                    m_cnt[c] = m_cntwd[c];
                end
                if (m_clr[c]) begin
                    m_cnt[c] = '0;
                end
                if (m_evc[c]) begin
                    m_evn[c] = '0;
                end
                m_clr[c]   = 1'b0;
                m_evc[c]   = 1'b0;
                m_cntwr[c] = 1'b0;
            end

            if (accept && write_i) begin
                ch  = int'(addr_i) / timer_map_pkg::CH_STRIDE;
                off = int'(addr_i) % timer_map_pkg::CH_STRIDE;
                if (ch < timer_cfg_pkg::NUM_CHANNELS) begin
                    case (off)
                        timer_map_pkg::REG_PRE: m_pre[ch] = merge_bytes(m_pre[ch], wdata_i, be_i);
                        timer_map_pkg::REG_ARE: m_are[ch] = merge_bytes(m_are[ch], wdata_i, be_i);
                        timer_map_pkg::REG_CTRL: begin
                            merged = merge_bytes({30'b0, m_mod[ch], m_ena[ch]}, wdata_i, be_i);
                            m_ena[ch] = merged[timer_map_pkg::CTRL_ENA];
                            m_mod[ch] = merged[timer_map_pkg::CTRL_MOD];
                            m_clr[ch] = merged[timer_map_pkg::CTRL_CLR];
                            m_evc[ch] = merged[timer_map_pkg::CTRL_EVC];
                        end
                        timer_map_pkg::REG_CNT: begin
                            m_cntwr[ch] = 1'b1;
                            m_cntwd[ch] = merge_bytes(cnt_old[ch], wdata_i, be_i);
                        end
                        default: ;
                    endcase
                end else if (addr_i == timer_map_pkg::REG_IRQ_MASK) begin
                    merged = merge_bytes({30'b0, m_mask}, wdata_i, be_i);
                    m_mask = merged[1:0];
                end
            end

            if (accept) begin
                m_busy = 1'b1;
            end else if (!req_i) begin
                m_busy = 1'b0;
            end
        end
    end

    // outputs are settled by the falling edge
    always @(negedge clk_i) begin
        if (!rst_i) begin
            check_value("u_ctrl0.cnt", u_dut.u_ctrl0.cnt, m_cnt[0]);
            check_value("u_ctrl0.evn", u_dut.u_ctrl0.evn, m_evn[0]);
            check_value("u_ctrl1.cnt", u_dut.u_ctrl1.cnt, m_cnt[1]);
            check_value("u_ctrl1.evn", u_dut.u_ctrl1.evn, m_evn[1]);
            check_value("irq_o", timer_cfg_pkg::word_t'(irq_o), timer_cfg_pkg::word_t'(m_irq));
            check_value("ack_o", timer_cfg_pkg::word_t'(ack_o), timer_cfg_pkg::word_t'(m_busy));
        end
    end

    // a concurrent assertion failure ends the run at once
    always @(u_dut.u_assertions.fail_count) begin
        if (u_dut.u_assertions.fail_count != 0) begin
            report_fail($sformatf("%0d concurrent assertion failures",
                                  u_dut.u_assertions.fail_count));
        end
    end

    // one four-phase access entered and left 1 ns after a rising edge
    task automatic bus_access(input logic wr, input timer_cfg_pkg::addr_t addr,
                              input timer_cfg_pkg::word_t data, input timer_cfg_pkg::be_t be,
                              output timer_cfg_pkg::word_t rd);
        int gap;
        int hold;
        gap  = random_bits(2);
        hold = random_bits(2) + hold_extra;
        repeat (gap) begin
            @(posedge clk_i);
            #1;
        end
        req_i   = 1'b1;
        write_i = wr;
        addr_i  = addr;
        be_i    = be;
        wdata_i = data;
        do begin
            @(posedge clk_i);
            #1;
        end while (!ack_o);
        rd = rdata_o;
        if (!wr) begin
            check_value("rdata_o", rdata_o, m_rdata);
        end
        repeat (hold) begin
            @(posedge clk_i);
            #1;
            assert (ack_o) else report_fail("ack_o dropped while req_i was still held high");
        end
        req_i   = 1'b0;
        write_i = 1'b0;
        do begin
            @(posedge clk_i);
            #1;
        end while (ack_o);
    endtask

    task automatic do_write(timer_cfg_pkg::addr_t addr, timer_cfg_pkg::word_t data,
                            timer_cfg_pkg::be_t be);
        timer_cfg_pkg::word_t unused;
        bus_access(1'b1, addr, data, be, unused);
    endtask

    task automatic do_read(timer_cfg_pkg::addr_t addr, output timer_cfg_pkg::word_t data);
        bus_access(1'b0, addr, '0, '0, data);
    endtask

    task automatic pulse_irq_ack();
        irq_ack_i = 1'b1;
        @(posedge clk_i);
        #1;
        irq_ack_i = 1'b0;
    endtask

    task automatic wait_cycles(int n);
        repeat (n) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_fail("Watchdog expired before the tests finished");
    end

    initial begin : stimulus
        timer_cfg_pkg::word_t data;
        timer_cfg_pkg::word_t rd;
        timer_cfg_pkg::be_t   be;
        timer_cfg_pkg::addr_t addr;
        int                   sel;
        int                   ch;
        rst_i     = 1'b1;
        req_i     = 1'b0;
        write_i   = 1'b0;
        addr_i    = '0;
        be_i      = '0;
        wdata_i   = '0;
        irq_ack_i = 1'b0;
        repeat (16) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        // register access with random byte enables while the channels stay stopped
        for (int i = 0; i < 24; i++) begin
            sel  = random_bits(2);
            ch   = random_bits(1);
            data = random_bits(32);
            be   = random_bits(4);
            case (sel)
                0:       addr = chan_addr(ch, timer_map_pkg::REG_PRE);
                1:       addr = chan_addr(ch, timer_map_pkg::REG_ARE);
                2:       addr = chan_addr(ch, timer_map_pkg::REG_CTRL);
                default: addr = timer_map_pkg::REG_IRQ_MASK;
            endcase
            if (sel == 2) begin
                data[timer_map_pkg::CTRL_ENA] = 1'b0;
            end
            do_write(addr, data, be);
            do_read(addr, rd);
        end
        foreach (unmapped[i]) begin
            do_read(unmapped[i], rd);
            check_value("rdata_o unmapped", rd, '0);
        end

        // channel 0 counting up every 3 clocks with reload at 4
        do_write(timer_map_pkg::REG_IRQ_MASK, 32'h0, 4'hf);
        do_write(chan_addr(0, timer_map_pkg::REG_PRE), 32'd2, 4'hf);
        do_write(chan_addr(0, timer_map_pkg::REG_ARE), 32'd4, 4'hf);
        do_write(chan_addr(0, timer_map_pkg::REG_CTRL), 32'h3, 4'hf);
        for (int i = 0; i < 10; i++) begin
            wait_cycles(random_bits(3));
            do_read(chan_addr(0, timer_map_pkg::REG_CNT), rd);
            do_read(chan_addr(0, timer_map_pkg::REG_EVN), rd);
        end

        // channel 1 counting down on the default divide and wrapping below zero
        do_write(chan_addr(1, timer_map_pkg::REG_PRE), 32'hffff_ffff, 4'hf);
        do_write(chan_addr(1, timer_map_pkg::REG_ARE), 32'hffff_fffc, 4'hf);
        do_write(chan_addr(1, timer_map_pkg::REG_CTRL), 32'h1, 4'hf);
        for (int i = 0; i < 8; i++) begin
            wait_cycles(random_bits(3));
            do_read(chan_addr(1, timer_map_pkg::REG_CNT), rd);
        end

        // clears while running and then a count load
        do_write(chan_addr(0, timer_map_pkg::REG_CTRL), 32'h7, 4'hf);
        do_read(chan_addr(0, timer_map_pkg::REG_CNT), rd);
        do_write(chan_addr(0, timer_map_pkg::REG_CTRL), 32'hb, 4'hf);
        do_read(chan_addr(0, timer_map_pkg::REG_EVN), rd);
        do_read(chan_addr(0, timer_map_pkg::REG_CTRL), rd);
        do_write(chan_addr(0, timer_map_pkg::REG_CNT), 32'd2, 4'hf);
        do_read(chan_addr(0, timer_map_pkg::REG_CNT), rd);
        do_write(chan_addr(1, timer_map_pkg::REG_CTRL), 32'h5, 4'hf);
        do_read(chan_addr(1, timer_map_pkg::REG_CNT), rd);

        // interrupt merge with both channels running
        do_write(timer_map_pkg::REG_IRQ_MASK, 32'h1, 4'h1);
        do begin
            wait_cycles(1);
        end while (!m_pend[0]);
        do_read(timer_map_pkg::REG_IRQ_PEND, rd);
        pulse_irq_ack();
        do_read(timer_map_pkg::REG_IRQ_PEND, rd);
        // acknowledge in the very cycle of a channel 0 event
        do begin
            wait_cycles(1);
        end while (!m_evp[0]);
        pulse_irq_ack();
        do_read(timer_map_pkg::REG_IRQ_PEND, rd);
        do_write(timer_map_pkg::REG_IRQ_MASK, 32'h3, 4'hf);
        wait_cycles(40);
        do_read(timer_map_pkg::REG_IRQ_PEND, rd);
        do_write(timer_map_pkg::REG_IRQ_MASK, 32'h2, 4'hf);
        pulse_irq_ack();
        wait_cycles(40);
        do_read(timer_map_pkg::REG_IRQ_PEND, rd);
        pulse_irq_ack();

        // back-pressure with the request held well past the ack
        hold_extra = 12;
        do_write(chan_addr(0, timer_map_pkg::REG_ARE), 32'd6, 4'hf);
        hold_extra = 0;
        do_read(chan_addr(0, timer_map_pkg::REG_ARE), rd);
        do_read(chan_addr(0, timer_map_pkg::REG_CNT), rd);

        wait_cycles(4);
        $display("All tests passed!");
        $finish;
    end

endmodule
